// ==== design/airHockey_consts.svh ====
`ifndef AIRHOCKEY_CONSTS_SVH
`define AIRHOCKEY_CONSTS_SVH

//////////////////////////////
// Playfield geometry
//////////////////////////////

// OLED size in pixels
`define SCREEN_W       96
`define SCREEN_H       64

// Paddle spans centre-7 .. centre+6, 14 rows
`define PADDLE_HALF    7
// Gap between screen edge and paddle centre column
`define BORDER         3
// Largest paddle step per tick
`define PIXEL_MOVE     3

// Legal range of paddle centre rows
`define PADDLE_Y_MIN   7
`define PADDLE_Y_MAX   57
`define PADDLE_Y_HOME  32

// Serve point of the puck
`define PUCK_X_HOME    48
`define PUCK_Y_HOME    32

//////////////////////////////
// RGB565 colours
//////////////////////////////

`define COL_PUCK       16'hFFFF
`define COL_USER       16'hF800
`define COL_AUDIO      16'h001F
`define COL_BG         16'h0000

`endif

// ==== design/airHockeyPkg.sv ====
package airHockeyPkg;

    //////////////////////////////
    // Screen coordinates
    //////////////////////////////

    // Column 0..95
    typedef logic [6:0] xCoordT;
    // Row 0..63
    typedef logic [5:0] yCoordT;

    //////////////////////////////
    // Game objects
    //////////////////////////////

    // Paddle centre, x column is fixed per side
    typedef struct packed {
        xCoordT x;
        yCoordT y;
    } paddlePosT;

    // Puck position and travel direction
    typedef struct packed {
        xCoordT x;
        yCoordT y;
        logic   dxPos;  // 1 = moving right
        logic   dyPos;  // 1 = moving down
    } puckStateT;

    // Goal counter, saturates at 15
    typedef logic [3:0] scoreT;

    // One RGB565 pixel
    typedef logic [15:0] pixelColorT;

endpackage

// ==== design/airHockeyPaddles.sv ====
`timescale 1ns/1ps
`include "airHockey_consts.svh"

module airHockeyPaddles (
    input  logic                   clkPaddle,
    input  logic                   rstN,
    input  logic                   btnU,
    input  logic                   btnD,
    input  logic                   sw15,
    input  logic [3:0]             num,
    input  airHockeyPkg::xCoordT   x,
    input  airHockeyPkg::yCoordT   y,
    output airHockeyPkg::paddlePosT userPaddle,
    output airHockeyPkg::paddlePosT audioPaddle,
    output logic                   userPaddleAppear,
    output logic                   audioPaddleAppear
);
    import airHockeyPkg::*;

    // Fixed centre columns, 3 and 92
    localparam xCoordT USER_X  = xCoordT'(`BORDER);
    localparam xCoordT AUDIO_X = xCoordT'(`SCREEN_W - 1 - `BORDER);
    // Paddle is 3 columns wide
    localparam xCoordT HALF_W  = 7'd1;
    localparam yCoordT HALF_H  = yCoordT'(`PADDLE_HALF);
    localparam yCoordT STEP    = yCoordT'(`PIXEL_MOVE);
    localparam yCoordT Y_MIN   = yCoordT'(`PADDLE_Y_MIN);
    localparam yCoordT Y_MAX   = yCoordT'(`PADDLE_Y_MAX);
    localparam yCoordT Y_HOME  = yCoordT'(`PADDLE_Y_HOME);

    // Centre rows, the only paddle state
    yCoordT userY;
    yCoordT audioY;

    yCoordT userYNext;
    yCoordT audioYNext;
    yCoordT audioTarget;
    yCoordT audioGap;

    // Pixel inside the 3x14 box around a centre
    function automatic logic inPaddle(input paddlePosT p, input xCoordT px,
                                      input yCoordT py);
        logic inCols;
        logic inRows;
        inCols = (px >= p.x - HALF_W) && (px <= p.x + HALF_W);
        // Centre never below 7 or above 57, so no wrap here
        inRows = (py >= p.y - HALF_H) && (py <= p.y + HALF_H - 6'd1);
        return inCols && inRows;
    endfunction

    //////////////////////////////
    // User paddle
    //////////////////////////////

    always_comb begin
        userYNext = userY;
        // Up beats down when both pressed
        if (btnU) begin
            userYNext = (userY >= Y_MIN + STEP) ? userY - STEP : Y_MIN;
        end else if (btnD) begin
            userYNext = (userY + STEP <= Y_MAX) ? userY + STEP : Y_MAX;
        end
    end

    //////////////////////////////
    // Audio paddle
    //////////////////////////////

    // Target row 7 + 3*num, so 7..52
    assign audioTarget = Y_MIN + yCoordT'(num) * STEP;

    always_comb begin
        audioYNext = audioY;
        audioGap   = '0;
        // Close in by min(3, distance)
        if (audioTarget > audioY) begin
            audioGap   = audioTarget - audioY;
            audioYNext = audioY + ((audioGap > STEP) ? STEP : audioGap);
        end else if (audioTarget < audioY) begin
            audioGap   = audioY - audioTarget;
            audioYNext = audioY - ((audioGap > STEP) ? STEP : audioGap);
        end
    end

    // Restart switch overrides all movement
    always_ff @(posedge clkPaddle or negedge rstN) begin
        if (!rstN) begin
            userY  <= Y_HOME;
            audioY <= Y_HOME;
        end else if (sw15) begin
            userY  <= Y_HOME;
            audioY <= Y_HOME;
        end else begin
            userY  <= userYNext;
            audioY <= audioYNext;
        end
    end

    assign userPaddle  = '{x: USER_X, y: userY};
    assign audioPaddle = '{x: AUDIO_X, y: audioY};

    // Hit flags for the renderer, no latency
    assign userPaddleAppear  = inPaddle(userPaddle, x, y);
    assign audioPaddleAppear = inPaddle(audioPaddle, x, y);

endmodule

// ==== design/airHockeyPuck.sv ====
`timescale 1ns/1ps
`include "airHockey_consts.svh"

module airHockeyPuck (
    input  logic                    clkPaddle,
    input  logic                    rstN,
    input  logic                    sw15,
    input  airHockeyPkg::xCoordT    x,
    input  airHockeyPkg::yCoordT    y,
    input  airHockeyPkg::paddlePosT userPaddle,
    input  airHockeyPkg::paddlePosT audioPaddle,
    output airHockeyPkg::puckStateT puckState,
    output logic                    puckAppear,
    output airHockeyPkg::scoreT     scoreUser,
    output airHockeyPkg::scoreT     scoreAudio
);
    import airHockeyPkg::*;

    localparam xCoordT X_HOME  = xCoordT'(`PUCK_X_HOME);
    localparam yCoordT Y_HOME  = yCoordT'(`PUCK_Y_HOME);
    localparam xCoordT X_LAST  = xCoordT'(`SCREEN_W - 1);
    localparam yCoordT Y_LAST  = yCoordT'(`SCREEN_H - 1);
    localparam yCoordT HALF_H  = yCoordT'(`PADDLE_HALF);
    // Puck rebounds two columns in front of a paddle centre
    localparam xCoordT REBOUND = 7'd2;
    localparam scoreT  SCORE_MAX = 4'd15;
    // Serve after reset or restart goes right and down
    localparam puckStateT PUCK_HOME = '{x: X_HOME, y: Y_HOME, dxPos: 1'b1, dyPos: 1'b1};

    puckStateT puckNext;
    scoreT     scoreUserNext;
    scoreT     scoreAudioNext;
    logic      dxNext;
    logic      dyNext;

    logic goalAudio;
    logic goalUser;
    logic hitUser;
    logic hitAudio;
    logic hitWall;

    // Puck row inside the 14-row span of a paddle centre
    function automatic logic rowInSpan(input yCoordT centre, input yCoordT row);
        return (row >= centre - HALF_H) && (row <= centre + HALF_H - 6'd1);
    endfunction

    function automatic scoreT satInc(input scoreT s);
        return (s == SCORE_MAX) ? s : s + 4'd1;
    endfunction

    //////////////////////////////
    // Event detection
    //////////////////////////////

    // Leaving at the left edge, point to audio side
    assign goalAudio = !puckState.dxPos && (puckState.x == '0);
    // Leaving at the right edge, point to user side
    assign goalUser  = puckState.dxPos && (puckState.x == X_LAST);

    // Paddle positions from before the edge
    assign hitUser  = !puckState.dxPos
                   && (puckState.x == userPaddle.x + REBOUND)
                   && rowInSpan(userPaddle.y, puckState.y);
    assign hitAudio = puckState.dxPos
                   && (puckState.x == audioPaddle.x - REBOUND)
                   && rowInSpan(audioPaddle.y, puckState.y);

    // Top and bottom walls
    assign hitWall = (!puckState.dyPos && (puckState.y == '0))
                  || (puckState.dyPos && (puckState.y == Y_LAST));

    //////////////////////////////
    // Next state, rules in order
    //////////////////////////////

    always_comb begin
        puckNext       = puckState;
        scoreUserNext  = scoreUser;
        scoreAudioNext = scoreAudio;
        dxNext         = puckState.dxPos ^ (hitUser || hitAudio);
        dyNext         = puckState.dyPos ^ hitWall;
        if (sw15) begin
            puckNext       = PUCK_HOME;
            scoreUserNext  = '0;
            scoreAudioNext = '0;
        end else if (goalAudio) begin
            // Serve toward the user side, vertical kept
            puckNext.x     = X_HOME;
            puckNext.y     = Y_HOME;
            puckNext.dxPos = 1'b0;
            scoreAudioNext = satInc(scoreAudio);
        end else if (goalUser) begin
            puckNext.x     = X_HOME;
            puckNext.y     = Y_HOME;
            puckNext.dxPos = 1'b1;
            scoreUserNext  = satInc(scoreUser);
        end else begin
            // Step one pixel along the updated directions
            puckNext.dxPos = dxNext;
            puckNext.dyPos = dyNext;
            puckNext.x     = dxNext ? puckState.x + 7'd1 : puckState.x - 7'd1;
            puckNext.y     = dyNext ? puckState.y + 6'd1 : puckState.y - 6'd1;
        end
    end

    always_ff @(posedge clkPaddle or negedge rstN) begin
        if (!rstN) begin
            puckState  <= PUCK_HOME;
            scoreUser  <= '0;
            scoreAudio <= '0;
        end else begin
            puckState  <= puckNext;
            scoreUser  <= scoreUserNext;
            scoreAudio <= scoreAudioNext;
        end
    end

    // Single pixel puck
    assign puckAppear = (x == puckState.x) && (y == puckState.y);

endmodule

// ==== design/airHockeyRenderer.sv ====
`timescale 1ns/1ps
`include "airHockey_consts.svh"

module airHockeyRenderer (
    input  logic                     puckAppear,
    input  logic                     userPaddleAppear,
    input  logic                     audioPaddleAppear,
    output airHockeyPkg::pixelColorT pixelColor
);
    import airHockeyPkg::*;

    //////////////////////////////
    // Palette
    //////////////////////////////

    // White puck
    localparam pixelColorT PUCK_COL  = `COL_PUCK;
    // Red for the button player
    localparam pixelColorT USER_COL  = `COL_USER;
    // Blue for the volume player
    localparam pixelColorT AUDIO_COL = `COL_AUDIO;
    // Black field
    localparam pixelColorT BG_COL    = `COL_BG;

    //////////////////////////////
    // Priority select
    //////////////////////////////

    // Purely combinational, same cycle as the coordinate
    always_comb begin
        // Puck on top so it shows over a paddle
        if (puckAppear) begin
            pixelColor = PUCK_COL;
        end else if (userPaddleAppear) begin
            pixelColor = USER_COL;
        end else if (audioPaddleAppear) begin
            // Paddles never overlap, order here is arbitrary
            pixelColor = AUDIO_COL;
        end else begin
            pixelColor = BG_COL;
        end
    end

endmodule

// ==== design/airHockeyTop.sv ====
`timescale 1ns/1ps

module airHockeyTop (
    input  logic                    clkPaddle,
    input  logic                    rstN,
    input  logic                    btnU,
    input  logic                    btnD,
    input  logic                    sw15,
    input  logic [3:0]              num,
    input  airHockeyPkg::xCoordT    x,
    input  airHockeyPkg::yCoordT    y,
    output airHockeyPkg::pixelColorT pixelColor,
    output airHockeyPkg::paddlePosT userPaddle,
    output airHockeyPkg::paddlePosT audioPaddle,
    output airHockeyPkg::puckStateT puckState,
    output airHockeyPkg::scoreT     scoreUser,
    output airHockeyPkg::scoreT     scoreAudio
);

    // Per-pixel hit flags into the renderer
    logic userPaddleAppear;
    logic audioPaddleAppear;
    logic puckAppear;

    //////////////////////////////
    // Game state
    //////////////////////////////

    // Buttons and volume drive the paddles
    airHockeyPaddles uPaddles (
        .clkPaddle        (clkPaddle),
        .rstN             (rstN),
        .btnU             (btnU),
        .btnD             (btnD),
        .sw15             (sw15),
        .num              (num),
        .x                (x),
        .y                (y),
        .userPaddle       (userPaddle),
        .audioPaddle      (audioPaddle),
        .userPaddleAppear (userPaddleAppear),
        .audioPaddleAppear(audioPaddleAppear)
    );

    // Puck bounces off the registered paddle positions
    airHockeyPuck uPuck (
        .clkPaddle  (clkPaddle),
        .rstN       (rstN),
        .sw15       (sw15),
        .x          (x),
        .y          (y),
        .userPaddle (userPaddle),
        .audioPaddle(audioPaddle),
        .puckState  (puckState),
        .puckAppear (puckAppear),
        .scoreUser  (scoreUser),
        .scoreAudio (scoreAudio)
    );

    //////////////////////////////
    // Display path
    //////////////////////////////

    airHockeyRenderer uRenderer (
        .puckAppear       (puckAppear),
        .userPaddleAppear (userPaddleAppear),
        .audioPaddleAppear(audioPaddleAppear),
        .pixelColor       (pixelColor)
    );

endmodule

// ==== verif/airHockeyClkGen.sv ====
`timescale 1ns/1ps

module airHockeyClkGen (
    output logic clkPaddle,
    output logic rstN
);

    // 40 ns game tick
    initial begin
        clkPaddle = 1'b0;
        forever #20 clkPaddle = ~clkPaddle;
    end

    // Reset held for five rising edges
    initial begin
        rstN <= 1'b0;
        repeat (5) @(posedge clkPaddle);
        rstN <= 1'b1;
    end

endmodule

// ==== verif/airHockeyChk.sv ====
`timescale 1ns/1ps
`include "airHockey_consts.svh"

module airHockeyChk (
    input logic                     clkPaddle,
    input logic                     rstN,
    input logic                     sw15,
    input airHockeyPkg::paddlePosT  userPaddle,
    input airHockeyPkg::paddlePosT  audioPaddle,
    input airHockeyPkg::puckStateT  puckState,
    input airHockeyPkg::pixelColorT pixelColor
);
    import airHockeyPkg::*;

    //////////////////////////////
    // Range checks
    //////////////////////////////

    // Paddle centres inside the clamp window
    paddleRange: assert property (@(posedge clkPaddle) disable iff (!rstN)
        (userPaddle.y >= 6'(`PADDLE_Y_MIN)) && (userPaddle.y <= 6'(`PADDLE_Y_MAX))
        && (audioPaddle.y >= 6'(`PADDLE_Y_MIN)) && (audioPaddle.y <= 6'(`PADDLE_Y_MAX)))
        else $error("paddle centre outside legal rows");

    // Row is 6 bits, so only the column can leave the screen
    puckOnScreen: assert property (@(posedge clkPaddle) disable iff (!rstN)
        puckState.x <= 7'(`SCREEN_W - 1))
        else $error("puck column off screen");

    // Renderer only knows four colours
    legalColour: assert property (@(posedge clkPaddle) disable iff (!rstN)
        (pixelColor == `COL_PUCK) || (pixelColor == `COL_USER)
        || (pixelColor == `COL_AUDIO) || (pixelColor == `COL_BG))
        else $error("pixel colour outside palette");

    //////////////////////////////
    // Restart
    //////////////////////////////

    // Everything home one tick after the switch
    restartHome: assert property (@(posedge clkPaddle) disable iff (!rstN)
        sw15 |=> (userPaddle.y == 6'(`PADDLE_Y_HOME))
              && (audioPaddle.y == 6'(`PADDLE_Y_HOME))
              && (puckState.x == 7'(`PUCK_X_HOME))
              && (puckState.y == 6'(`PUCK_Y_HOME)))
        else $error("restart did not return objects home");

endmodule

bind airHockeyTop airHockeyChk chk (
    .clkPaddle  (clkPaddle),
    .rstN       (rstN),
    .sw15       (sw15),
    .userPaddle (userPaddle),
    .audioPaddle(audioPaddle),
    .puckState  (puckState),
    .pixelColor (pixelColor)
);

// ==== verif/airHockeyTb.sv ====
`timescale 1ns/1ps
`include "airHockey_consts.svh"

module airHockeyTb;
    import airHockeyPkg::*;

    logic       clkPaddle;
    logic       rstN;
    logic       btnU;
    logic       btnD;
    logic       sw15;
    logic [3:0] num;
    xCoordT     xPix;
    yCoordT     yPix;

    pixelColorT pixelColor;
    paddlePosT  userPaddle;
    paddlePosT  audioPaddle;
    puckStateT  puckState;
    scoreT      scoreUser;
    scoreT      scoreAudio;

    // Reference game state
    int mUserY;
    int mAudioY;
    int mPx;
    int mPy;
    bit mDx;
    bit mDy;
    int mScoreU;
    int mScoreA;
    bit mGoal;

    // Stimulus control
    bit randomMode;
    bit restartReq;
    int btnRun;
    int btnSel;
    int numRun;
    int numSel;

    airHockeyClkGen clkGen (
        .clkPaddle(clkPaddle),
        .rstN     (rstN)
    );

    airHockeyTop uut (
        .clkPaddle  (clkPaddle),
        .rstN       (rstN),
        .btnU       (btnU),
        .btnD       (btnD),
        .sw15       (sw15),
        .num        (num),
        .x          (xPix),
        .y          (yPix),
        .pixelColor (pixelColor),
        .userPaddle (userPaddle),
        .audioPaddle(audioPaddle),
        .puckState  (puckState),
        .scoreUser  (scoreUser),
        .scoreAudio (scoreAudio)
    );

    //////////////////////////////
    // Failure and compare tasks
    //////////////////////////////

    task automatic stopRun();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkPaddle(input string what, input paddlePosT got, input paddlePosT exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s paddle at (%0d,%0d), expected (%0d,%0d)",
                     $time, what, got.x, got.y, exp.x, exp.y);
            stopRun();
        end
    endtask

    task automatic checkPuck(input puckStateT got, input puckStateT exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: puck (%0d,%0d) dx=%0b dy=%0b, expected (%0d,%0d) dx=%0b dy=%0b",
                     $time, got.x, got.y, got.dxPos, got.dyPos,
                     exp.x, exp.y, exp.dxPos, exp.dyPos);
            stopRun();
        end
    endtask

    task automatic checkScore(input string what, input scoreT got, input scoreT exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s score %0d, expected %0d", $time, what, got, exp);
            stopRun();
        end
    endtask

    task automatic checkPixel(input pixelColorT got, input pixelColorT exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: pixel (%0d,%0d) colour %h, expected %h",
                     $time, xPix, yPix, got, exp);
            stopRun();
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    task automatic modelHome();
        mUserY  = `PADDLE_Y_HOME;
        mAudioY = `PADDLE_Y_HOME;
        mPx     = `PUCK_X_HOME;
        mPy     = `PUCK_Y_HOME;
        mDx     = 1'b1;
        mDy     = 1'b1;
        mScoreU = 0;
        mScoreA = 0;
    endtask

    // One game tick from the inputs seen at the edge
    task automatic modelTick();
        int  oldU;
        int  oldA;
        int  gap;
        bit  hitU;
        bit  hitA;
        bit  wall;
        oldU  = mUserY;
        oldA  = mAudioY;
        mGoal = 1'b0;
        if (sw15) begin
            modelHome();
        end else begin
            // Up wins over down
            if (btnU) begin
                mUserY = (mUserY - `PIXEL_MOVE < `PADDLE_Y_MIN) ? `PADDLE_Y_MIN
                                                                 : mUserY - `PIXEL_MOVE;
            end else if (btnD) begin
                mUserY = (mUserY + `PIXEL_MOVE > `PADDLE_Y_MAX) ? `PADDLE_Y_MAX
                                                                 : mUserY + `PIXEL_MOVE;
            end
            // Audio follows 7 + 3*num
            gap = `PADDLE_Y_MIN + `PIXEL_MOVE * int'(num) - mAudioY;
            if (gap > `PIXEL_MOVE) gap = `PIXEL_MOVE;
            if (gap < -`PIXEL_MOVE) gap = -`PIXEL_MOVE;
            mAudioY += gap;
            // Puck goals come first
            if (!mDx && mPx == 0) begin
                mScoreA = (mScoreA == 15) ? 15 : mScoreA + 1;
                mPx   = `PUCK_X_HOME;
                mPy   = `PUCK_Y_HOME;
                mDx   = 1'b0;
                mGoal = 1'b1;
            end else if (mDx && mPx == `SCREEN_W - 1) begin
                mScoreU = (mScoreU == 15) ? 15 : mScoreU + 1;
                mPx   = `PUCK_X_HOME;
                mPy   = `PUCK_Y_HOME;
                mDx   = 1'b1;
                mGoal = 1'b1;
            end else begin
                // Bounce tests use old paddle rows
                hitU = !mDx && (mPx == `BORDER + 2)
                    && (mPy >= oldU - `PADDLE_HALF) && (mPy <= oldU + `PADDLE_HALF - 1);
                hitA = mDx && (mPx == `SCREEN_W - 1 - `BORDER - 2)
                    && (mPy >= oldA - `PADDLE_HALF) && (mPy <= oldA + `PADDLE_HALF - 1);
                wall = (!mDy && mPy == 0) || (mDy && mPy == `SCREEN_H - 1);
                mDx  = mDx ^ (hitU || hitA);
                mDy  = mDy ^ wall;
                mPx  = mDx ? mPx + 1 : mPx - 1;
                mPy  = mDy ? mPy + 1 : mPy - 1;
            end
        end
    endtask

    function automatic bit inBox(input int px, input int py, input int cx, input int cy);
        return (px >= cx - 1) && (px <= cx + 1)
            && (py >= cy - `PADDLE_HALF) && (py <= cy + `PADDLE_HALF - 1);
    endfunction

    // Puck over user over audio over background
    function automatic pixelColorT expectedPixel(input int px, input int py);
        if (px == mPx && py == mPy) return `COL_PUCK;
        if (inBox(px, py, `BORDER, mUserY)) return `COL_USER;
        if (inBox(px, py, `SCREEN_W - 1 - `BORDER, mAudioY)) return `COL_AUDIO;
        return `COL_BG;
    endfunction

    task automatic checkAll();
        paddlePosT expU;
        paddlePosT expA;
        puckStateT expP;
        expU.x     = xCoordT'(`BORDER);
        expU.y     = yCoordT'(mUserY);
        expA.x     = xCoordT'(`SCREEN_W - 1 - `BORDER);
        expA.y     = yCoordT'(mAudioY);
        expP.x     = xCoordT'(mPx);
        expP.y     = yCoordT'(mPy);
        expP.dxPos = mDx;
        expP.dyPos = mDy;
        checkPaddle("user", userPaddle, expU);
        checkPaddle("audio", audioPaddle, expA);
        checkPuck(puckState, expP);
        checkScore("user", scoreUser, scoreT'(mScoreU));
        checkScore("audio", scoreAudio, scoreT'(mScoreA));
        checkPixel(pixelColor, expectedPixel(int'(xPix), int'(yPix)));
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Random pixel or one aimed at the puck or a paddle edge
    task automatic aimCoords();
        int mode;
        int cx;
        int cy;
        int offX;
        int offY;
        mode = int'($urandom % 4);
        if (mode == 0) begin
            xPix <= xCoordT'($urandom % `SCREEN_W);
            yPix <= yCoordT'($urandom % `SCREEN_H);
        end else if (mode == 1) begin
            xPix <= xCoordT'(mPx);
            yPix <= yCoordT'(mPy);
        end else begin
            cx = (mode == 2) ? `BORDER : `SCREEN_W - 1 - `BORDER;
            cy = (mode == 2) ? mUserY : mAudioY;
            // Just inside and just outside each side
            case (int'($urandom % 4))
                0: offX = -2;
                1: offX = -1;
                2: offX = 1;
                default: offX = 2;
            endcase
            case (int'($urandom % 4))
                0: offY = -`PADDLE_HALF - 1;
                1: offY = -`PADDLE_HALF;
                2: offY = `PADDLE_HALF - 1;
                default: offY = `PADDLE_HALF;
            endcase
            xPix <= xCoordT'(cx + offX);
            yPix <= yCoordT'((cy + offY) & 63);
        end
    endtask

    task automatic chooseInputs();
        if (randomMode) begin
            // Buttons held for long runs
            if (btnRun == 0) begin
                btnRun = 1 + int'($urandom % 40);
                btnSel = int'($urandom % 4);
            end
            btnRun--;
            if (numRun == 0) begin
                numRun = 1 + int'($urandom % 30);
                numSel = int'($urandom % 16);
            end
            numRun--;
            btnU <= (btnSel == 1) || (btnSel == 3);
            btnD <= (btnSel >= 2);
            num  <= 4'(numSel);
            sw15 <= restartReq || (($urandom % 250) == 0);
        end else begin
            // Fixed play where the puck misses both paddles
            btnU <= 1'b0;
            btnD <= 1'b0;
            num  <= 4'd8;
            sw15 <= restartReq;
        end
        restartReq = 1'b0;
        aimCoords();
    endtask

    // Model update and new inputs at the edge then a check at the falling edge
    task automatic tick();
        @(posedge clkPaddle);
        modelTick();
        chooseInputs();
        @(negedge clkPaddle);
        checkAll();
    endtask

    //////////////////////////////
    // Waits
    //////////////////////////////

    task automatic waitReset();
        int cycles;
        cycles = 0;
        @(negedge clkPaddle);
        while (rstN !== 1'b1) begin
            @(negedge clkPaddle);
            cycles++;
            if (cycles > 20) begin
                $display("Timeout: reset was never released");
                stopRun();
            end
        end
    endtask

    task automatic waitGoal();
        int cycles;
        cycles = 0;
        mGoal  = 1'b0;
        while (!mGoal) begin
            tick();
            cycles++;
            if (cycles > 100) begin
                $display("Timeout: no goal scored within 100 ticks");
                stopRun();
            end
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        void'($urandom(97));
        randomMode = 1'b0;
        restartReq = 1'b0;
        btnRun     = 0;
        btnSel     = 0;
        numRun     = 0;
        numSel     = 0;
        mGoal      = 1'b0;
        btnU <= 1'b0;
        btnD <= 1'b0;
        sw15 <= 1'b0;
        num  <= 4'd0;
        xPix <= '0;
        yPix <= '0;
        modelHome();

        // Home values right after reset
        waitReset();
        checkAll();

        // Restart then repeated user goals up to saturation
        restartReq = 1'b1;
        tick();
        for (int g = 0; g < 17; g++) begin
            waitGoal();
        end

        // Long random game with restarts
        randomMode = 1'b1;
        for (int t = 0; t < 6000; t++) begin
            tick();
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+design
design/airHockeyPkg.sv
design/airHockeyPaddles.sv
design/airHockeyPuck.sv
design/airHockeyRenderer.sv
design/airHockeyTop.sv
verif/airHockeyClkGen.sv
verif/airHockeyChk.sv
verif/airHockeyTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and simulate the air hockey testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f verilog.f \
    --top-module airHockeyTb \
    -o simAirHockey

# The simulation exits non-zero on failure, the log decides the result
./obj_dir/simAirHockey > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
